// ==== design/acc_result.sv ====
// Result stage of the remote arithmetic unit
// Owns the running accumulator for ACC and CLR and drives the final result
// strobe with data, carry and error

`timescale 1ns/1ps

module acc_result (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                exe_valid,
  input  ralu_pkg::ralu_exe_t exe_res,
  output logic                res_valid,
  output ralu_pkg::data_t     res_data,
  output logic                res_carry,
  output logic                res_err
);

  ralu_pkg::data_t acc;
  logic [16:0]     acc_sum;
  logic            is_acc;
  logic            is_clr;

  assign is_acc = (exe_res.op == ralu_pkg::OP_ACC);
  assign is_clr = (exe_res.op == ralu_pkg::OP_CLR);

  // Next accumulator value with the wrap carry in bit 16
  assign acc_sum = {1'b0, acc} + {1'b0, exe_res.value};

  // ------------------------------
  // Accumulator and strobe
  // ------------------------------
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      acc       <= '0;
      res_valid <= 1'b0;
    end else begin
      res_valid <= exe_valid;
      if (exe_valid && is_acc) begin
        acc <= acc_sum[15:0];
      end else if (exe_valid && is_clr) begin
        acc <= '0;
      end
      // Illegal and plain ALU ops leave the accumulator alone
    end
  end

  // ------------------------------
  // Result payload
  // ------------------------------
  always_ff @(posedge clk) begin
    if (exe_valid) begin
      if (is_acc) begin
        // Report the new accumulator, same value that lands in acc
        res_data  <= acc_sum[15:0];
        res_carry <= acc_sum[16];
        res_err   <= 1'b0;
      end else if (is_clr) begin
        res_data  <= '0;
        res_carry <= 1'b0;
        res_err   <= 1'b0;
      end else begin
        res_data  <= exe_res.value;
        res_carry <= exe_res.carry;
        res_err   <= exe_res.err;
      end
    end
  end

endmodule

// ==== design/alu_execute.sv ====
// Execute stage of the remote arithmetic unit
// Takes the delayed command, does add, subtract, AND or XOR and registers
// the result with its carry and error flags

`timescale 1ns/1ps

module alu_execute (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                xp_valid_next,
  input  ralu_pkg::ralu_cmd_t xp_cmd,
  output logic                exe_valid,
  output ralu_pkg::ralu_exe_t exe_res
);

  logic                data_vld;
  logic [16:0]         add_sum;
  logic [16:0]         sub_diff;
  ralu_pkg::ralu_exe_t exe_d;

  // Delayed valid-next becomes the cycle in which xp_cmd holds real data
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      data_vld <= 1'b0;
    end else begin
      data_vld <= xp_valid_next;
    end
  end

  // ------------------------------
  // Arithmetic and logic
  // ------------------------------

  // Bit 16 keeps the carry of the add and the borrow of the subtract
  assign add_sum  = {1'b0, xp_cmd.a} + {1'b0, xp_cmd.b};
  assign sub_diff = {1'b0, xp_cmd.a} - {1'b0, xp_cmd.b};

  always_comb begin
    exe_d.op    = xp_cmd.op;
    exe_d.value = '0;
    exe_d.carry = 1'b0;
    exe_d.err   = 1'b0;
    case (xp_cmd.op)
      ralu_pkg::OP_ADD: begin
        exe_d.value = add_sum[15:0];
        exe_d.carry = add_sum[16];
      end
      ralu_pkg::OP_SUB: begin
        exe_d.value = sub_diff[15:0];
        exe_d.carry = sub_diff[16];
      end
      ralu_pkg::OP_AND: exe_d.value = xp_cmd.a & xp_cmd.b;
      ralu_pkg::OP_XOR: exe_d.value = xp_cmd.a ^ xp_cmd.b;
      // Result stage adds this to the accumulator
      ralu_pkg::OP_ACC: exe_d.value = xp_cmd.a;
      // CLR leaves the zero value from above
      ralu_pkg::OP_CLR: exe_d.value = '0;
      default:          exe_d.err   = 1'b1;
    endcase
  end

  // ------------------------------
  // Output registers
  // ------------------------------
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      exe_valid <= 1'b0;
    end else begin
      exe_valid <= data_vld;
    end
  end

  always_ff @(posedge clk) begin
    if (data_vld) begin
      exe_res <= exe_d;
    end
  end

endmodule

// ==== design/br_delay_valid_next_nr.sv ====
// Delay line for a valid-next flag and its data word
// The flag runs one cycle ahead of the data at every stage, and each data
// register only loads in the cycle its own flag marks as valid

`timescale 1ns/1ps

module br_delay_valid_next_nr #(
  parameter int bit_width  = 1,
  parameter int num_stages = 0
) (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 in_valid_next,
  input  logic [bit_width-1:0] in,
  output logic                 out_valid_next,
  output logic [bit_width-1:0] out
);

  // Index 0 is the input side, index num_stages the output side
  logic [num_stages:0]                stage_valid_next;
  logic [num_stages:0][bit_width-1:0] stage;

  assign stage_valid_next[0] = in_valid_next;
  assign stage[0]            = in;

  // ------------------------------
  // Stage chain
  // ------------------------------
  for (genvar i = 1; i <= num_stages; i++) begin : gen_stages
    // Flag flop keeps the control side quiet after reset
    always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
        stage_valid_next[i] <= 1'b0;
      end else begin
        stage_valid_next[i] <= stage_valid_next[i-1];
      end
    end

    // The flag of stage i lines up with the data still sitting in stage i-1,
    // so it serves as the load enable for this data register
    always_ff @(posedge clk) begin
      if (stage_valid_next[i]) begin
        stage[i] <= stage[i-1];
      end
    end
  end

  // With zero stages both outputs are the inputs unchanged
  assign out_valid_next = stage_valid_next[num_stages];
  assign out            = stage[num_stages];

endmodule

// ==== design/cmd_decode.sv ====
// Front end of the remote arithmetic unit
// Classifies the raw opcode, captures the command and hands the strobe on
// as a valid-next flag one cycle ahead of the registered command

`timescale 1ns/1ps

module cmd_decode (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                cmd_valid,
  input  ralu_pkg::raw_op_t   cmd_op,
  input  ralu_pkg::data_t     cmd_a,
  input  ralu_pkg::data_t     cmd_b,
  output logic                dec_valid_next,
  output ralu_pkg::ralu_cmd_t dec_cmd
);

  ralu_pkg::op_t   op_class;
  ralu_pkg::op_t   op_q;
  ralu_pkg::data_t a_q;
  ralu_pkg::data_t b_q;

  // ------------------------------
  // Opcode classification
  // ------------------------------
  always_comb begin
    case (cmd_op)
      3'd0:    op_class = ralu_pkg::OP_ADD;
      3'd1:    op_class = ralu_pkg::OP_SUB;
      3'd2:    op_class = ralu_pkg::OP_AND;
      3'd3:    op_class = ralu_pkg::OP_XOR;
      3'd4:    op_class = ralu_pkg::OP_ACC;
      3'd5:    op_class = ralu_pkg::OP_CLR;
      // Codes 6 and 7 end up here
      default: op_class = ralu_pkg::OP_ILL;
    endcase
  end

  // The strobe leaves now and the command follows next cycle
  // This puts the wide fanout of the flag a cycle ahead of the data
  assign dec_valid_next = cmd_valid;

  // Opcode register starts out as illegal so stale state never looks like
  // a real operation
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      op_q <= ralu_pkg::OP_ILL;
    end else if (cmd_valid) begin
      op_q <= op_class;
    end
  end

  // Operand capture, loaded only on a command
  always_ff @(posedge clk) begin
    if (cmd_valid) begin
      a_q <= cmd_a;
      b_q <= cmd_b;
    end
  end

  assign dec_cmd.op = op_q;
  assign dec_cmd.a  = a_q;
  assign dec_cmd.b  = b_q;

endmodule

// ==== design/ralu_pkg.sv ====
// Shared types for the remote arithmetic unit
// Holds the operand word, the opcode encodings and the structs that move
// between decode, the delay line, execute and result

package ralu_pkg;

  // ------------------------------
  // Words and opcodes
  // ------------------------------

  // Width of one operand or result word
  localparam int DATA_BITS = 16;

  typedef logic [DATA_BITS-1:0] data_t;

  // Opcode exactly as the requester drives it on the port
  typedef logic [2:0] raw_op_t;

  // Classified opcode
  // Raw codes 6 and 7 have no meaning and both land on OP_ILL
  typedef enum logic [2:0] {
    OP_ADD = 3'd0,
    OP_SUB = 3'd1,
    OP_AND = 3'd2,
    OP_XOR = 3'd3,
    OP_ACC = 3'd4,
    OP_CLR = 3'd5,
    OP_ILL = 3'd7
  } op_t;

  // ------------------------------
  // Pipeline payloads
  // ------------------------------

  // Command as it crosses the long bus
  typedef struct packed {
    op_t   op;
    data_t a;
    data_t b;
  } ralu_cmd_t;

  // Bit count of a command, used as the delay line width
  localparam int CMD_BITS = $bits(ralu_cmd_t);

  // Executed result on its way to the accumulator stage
  typedef struct packed {
    op_t   op;
    data_t value;
    logic  carry;
    logic  err;
  } ralu_exe_t;

endpackage

// ==== design/remote_alu_top.sv ====
// Top level of the remote arithmetic unit
// A command strobed in at cycle T comes back on res_valid at T+num_stages+3,
// in order, with one command accepted per cycle

`timescale 1ns/1ps

module remote_alu_top #(
  parameter int num_stages = 3
) (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              cmd_valid,
  input  ralu_pkg::raw_op_t cmd_op,
  input  ralu_pkg::data_t   cmd_a,
  input  ralu_pkg::data_t   cmd_b,
  output logic              res_valid,
  output ralu_pkg::data_t   res_data,
  output logic              res_carry,
  output logic              res_err
);

  // Decode to delay line
  logic                dec_valid_next;
  ralu_pkg::ralu_cmd_t dec_cmd;

  // Delay line to execute
  logic                xp_valid_next;
  ralu_pkg::ralu_cmd_t xp_cmd;

  // Execute to result
  logic                exe_valid;
  ralu_pkg::ralu_exe_t exe_res;

  // ------------------------------
  // Pipeline
  // ------------------------------
  cmd_decode u_decode (
    .clk            (clk),
    .arst_n         (arst_n),
    .cmd_valid      (cmd_valid),
    .cmd_op         (cmd_op),
    .cmd_a          (cmd_a),
    .cmd_b          (cmd_b),
    .dec_valid_next (dec_valid_next),
    .dec_cmd        (dec_cmd)
  );

  // Long bus crossing, the flag stays a cycle ahead of the command
  br_delay_valid_next_nr #(
    .bit_width  (ralu_pkg::CMD_BITS),
    .num_stages (num_stages)
  ) u_xport (
    .clk            (clk),
    .arst_n         (arst_n),
    .in_valid_next  (dec_valid_next),
    .in             (dec_cmd),
    .out_valid_next (xp_valid_next),
    .out            (xp_cmd)
  );

  alu_execute u_execute (
    .clk           (clk),
    .arst_n        (arst_n),
    .xp_valid_next (xp_valid_next),
    .xp_cmd        (xp_cmd),
    .exe_valid     (exe_valid),
    .exe_res       (exe_res)
  );

  acc_result u_result (
    .clk       (clk),
    .arst_n    (arst_n),
    .exe_valid (exe_valid),
    .exe_res   (exe_res),
    .res_valid (res_valid),
    .res_data  (res_data),
    .res_carry (res_carry),
    .res_err   (res_err)
  );

endmodule

// ==== sim.f ====
design/ralu_pkg.sv
design/br_delay_valid_next_nr.sv
design/cmd_decode.sv
design/alu_execute.sv
design/acc_result.sv
design/remote_alu_top.sv
tb/remote_alu_tb.sv

// ==== tb/remote_alu_stimulus.txt ====
// Columns in hex: group gap opcode a b exp_data exp_carry exp_err
// Opcodes 0 ADD, 1 SUB, 2 AND, 3 XOR, 4 ACC, 5 CLR, 6 and 7 illegal; group ff ends
// Group 1: first ACC after reset returns a
1 3 4 1234 0000 1234 0 0
// Group 2: arithmetic and logic with carry and borrow
2 0 0 1234 4321 5555 0 0
2 0 0 ffff 0001 0000 1 0
2 0 1 5555 1111 4444 0 0
2 1 1 0000 0001 ffff 1 0
2 0 2 f0f0 3c3c 3030 0 0
2 2 3 f0f0 3c3c cccc 0 0
2 0 0 8000 8000 0000 1 0
2 3 1 1234 1234 0000 0 0
// Group 3: accumulate with wrap, clear, restart from zero
3 0 4 1000 dead 2234 0 0
3 0 4 f000 0000 1234 1 0
3 1 4 0100 0000 1334 0 0
3 0 5 5555 aaaa 0000 0 0
3 0 4 0042 0000 0042 0 0
3 3 4 ffff 0000 0041 1 0
// Group 4: illegal codes leave the accumulator alone
4 0 6 1111 2222 0000 0 1
4 0 7 ffff ffff 0000 0 1
4 3 4 0001 0000 0042 0 0
// Group 5: back-to-back commands
5 0 0 0001 0002 0003 0 0
5 0 1 0010 0003 000d 0 0
5 0 3 aaaa 5555 ffff 0 0
5 0 2 aaaa ffff aaaa 0 0
5 0 4 0008 0000 004a 0 0
5 0 0 7fff 8001 0000 1 0
5 0 1 0003 0005 fffe 1 0
5 4 4 0006 0000 0050 0 0
// Group 6: idle gaps between commands
6 5 3 1234 00ff 12cb 0 0
6 7 0 0100 0200 0300 0 0
6 4 4 0010 0000 0060 0 0
6 6 5 0000 0000 0000 0 0
6 3 6 abcd 1234 0000 0 1
6 2 1 0001 0001 0000 0 0
// End marker
ff 0 0 0000 0000 0000 0 0

// ==== tb/remote_alu_tb.sv ====
// Self-checking testbench for the remote arithmetic unit
// Reads commands and expected results from the stimulus file, drives them on
// the falling clock edge and checks every result strobe for value and latency

`timescale 1ns/1ps

module remote_alu_tb;

  localparam int NUM_STAGES = 3;
  localparam int LATENCY    = NUM_STAGES + 3;
  localparam int MAX_CMDS   = 64;
  // Eight hex words per command line in the stimulus file
  localparam int WORDS      = 8;

  // One command line as read from the file
  typedef struct packed {
    logic [7:0]        group;
    logic [7:0]        gap;
    ralu_pkg::raw_op_t op;
    ralu_pkg::data_t   a;
    ralu_pkg::data_t   b;
    ralu_pkg::data_t   exp_data;
    logic              exp_carry;
    logic              exp_err;
  } stim_t;

  // Expected result waiting for its strobe
  typedef struct packed {
    logic [7:0]      group;
    logic            last;
    int              issue_cycle;
    ralu_pkg::data_t data;
    logic            carry;
    logic            err;
  } exp_t;

  logic              clk;
  logic              arst_n;
  logic              cmd_valid;
  ralu_pkg::raw_op_t cmd_op;
  ralu_pkg::data_t   cmd_a;
  ralu_pkg::data_t   cmd_b;
  logic              res_valid;
  ralu_pkg::data_t   res_data;
  logic              res_carry;
  logic              res_err;

  logic [15:0] stim_mem [0:MAX_CMDS*WORDS-1];
  stim_t       stim [0:MAX_CMDS-1];
  exp_t        exp_q [$];
  int          grp_err [0:255];
  int          num_cmds;
  int          total_gap;
  int          cycle_cnt;
  int          groups_passed;
  int          groups_failed;
  int          stray_cnt;
  bit          stim_loaded;

  remote_alu_top #(
    .num_stages (NUM_STAGES)
  ) dut0 (
    .clk       (clk),
    .arst_n    (arst_n),
    .cmd_valid (cmd_valid),
    .cmd_op    (cmd_op),
    .cmd_a     (cmd_a),
    .cmd_b     (cmd_b),
    .res_valid (res_valid),
    .res_data  (res_data),
    .res_carry (res_carry),
    .res_err   (res_err)
  );

  // ------------------------------
  // Clock and cycle count
  // ------------------------------
  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Cycle index advances on the rising edge and is read on the falling edge
  initial begin
    cycle_cnt = 0;
    forever begin
      @(posedge clk);
      cycle_cnt++;
    end
  end

  // ------------------------------
  // Helpers
  // ------------------------------
  task automatic check_value(input string name, input logic [15:0] actual,
                             input logic [15:0] expected, input int grp);
    if (actual !== expected) begin
      $display("CHECK FAILED: %s got 0x%h expected 0x%h (group %0d)",
               name, actual, expected, grp);
      grp_err[grp]++;
    end
  endtask

  function automatic string group_label(input int g);
    case (g)
      1:       return "reset state";
      2:       return "arithmetic and logic";
      3:       return "accumulator";
      4:       return "illegal opcodes";
      5:       return "back-to-back pipelining";
      6:       return "gapped traffic";
      default: return "extra";
    endcase
  endfunction

  task automatic report_group(input int g);
    if (grp_err[g] == 0) begin
      $display("Group %0d (%s): passed", g, group_label(g));
      groups_passed++;
    end else begin
      $display("Group %0d (%s): FAILED with %0d errors", g, group_label(g), grp_err[g]);
      groups_failed++;
    end
  endtask

  // ------------------------------
  // Driver
  // ------------------------------
  initial begin
    int   base;
    exp_t e;
    cmd_valid     = 1'b0;
    cmd_op        = '0;
    cmd_a         = '0;
    cmd_b         = '0;
    arst_n        = 1'b0;
    num_cmds      = 0;
    total_gap     = 0;
    groups_passed = 0;
    groups_failed = 0;
    stray_cnt     = 0;
    stim_loaded   = 1'b0;

    $readmemh("tb/remote_alu_stimulus.txt", stim_mem);
    // Group ff marks the end of the command list
    for (int i = 0; i < MAX_CMDS; i++) begin
      base = i * WORDS;
      if ($isunknown(stim_mem[base])) begin
        $display("Error: stimulus file missing or without an end marker");
        $display("Simulation failed");
        $finish;
      end
      if (stim_mem[base] == 16'h00ff) begin
        break;
      end
      stim[i].group     = stim_mem[base][7:0];
      stim[i].gap       = stim_mem[base+1][7:0];
      stim[i].op        = stim_mem[base+2][2:0];
      stim[i].a         = stim_mem[base+3];
      stim[i].b         = stim_mem[base+4];
      stim[i].exp_data  = stim_mem[base+5];
      stim[i].exp_carry = stim_mem[base+6][0];
      stim[i].exp_err   = stim_mem[base+7][0];
      total_gap        += stim[i].gap;
      num_cmds++;
    end
    stim_loaded = 1'b1;

    // Reset held for two cycles, then a quiet stretch with no commands
    repeat (2) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    repeat (4) @(negedge clk);

    for (int i = 0; i < num_cmds; i++) begin
      cmd_valid     = 1'b1;
      cmd_op        = stim[i].op;
      cmd_a         = stim[i].a;
      cmd_b         = stim[i].b;
      e.group       = stim[i].group;
      e.last        = (i == num_cmds - 1) || (stim[i+1].group != stim[i].group);
      e.issue_cycle = cycle_cnt;
      e.data        = stim[i].exp_data;
      e.carry       = stim[i].exp_carry;
      e.err         = stim[i].exp_err;
      exp_q.push_back(e);
      @(negedge clk);
      cmd_valid = 1'b0;
      repeat (stim[i].gap) @(negedge clk);
    end

    // Let the pipeline drain, then watch a little longer for stray strobes
    while (exp_q.size() != 0) @(negedge clk);
    repeat (NUM_STAGES + 2) @(negedge clk);

    $display("Summary: %0d groups passed, %0d groups failed, %0d stray results",
             groups_passed, groups_failed, stray_cnt);
    if (groups_failed == 0 && stray_cnt == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // ------------------------------
  // Monitor
  // ------------------------------
  // DUT outputs change on the rising edge, so the falling edge sees them settled
  initial begin
    exp_t e;
    forever begin
      @(negedge clk);
      if (arst_n) begin
        if ($isunknown(res_valid)) begin
          $display("Error: res_valid is unknown at cycle %0d", cycle_cnt);
          stray_cnt++;
        end else if (res_valid) begin
          if (exp_q.size() == 0) begin
            $display("Error: unexpected result at cycle %0d with no command outstanding",
                     cycle_cnt);
            stray_cnt++;
          end else begin
            e = exp_q.pop_front();
            if (cycle_cnt - e.issue_cycle != LATENCY) begin
              $display("Error: latency error in group %0d, result came %0d cycles after %s",
                       e.group, cycle_cnt - e.issue_cycle, "its command");
              grp_err[e.group]++;
            end
            check_value("res_data", res_data, e.data, e.group);
            check_value("res_carry", {15'b0, res_carry}, {15'b0, e.carry}, e.group);
            check_value("res_err", {15'b0, res_err}, {15'b0, e.err}, e.group);
            if (e.last) begin
              report_group(e.group);
            end
          end
        end
      end
    end
  end

  // ------------------------------
  // Watchdog
  // ------------------------------
  // Budget covers every command and gap plus the pipeline depth and some slack
  initial begin
    int limit;
    wait (stim_loaded);
    limit = num_cmds + total_gap + NUM_STAGES + 20;
    repeat (limit) @(posedge clk);
    $display("Error: timeout, the run did not finish within %0d cycles", limit);
    $display("Simulation failed");
    $finish;
  end

endmodule
